// File: Makefile
VERILATOR ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_ptw
RTL_TOP ?= ptw_top
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= \*\*\* PASSED \*\*\*

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
+incdir+.
ptw_pkg.sv
ptg_rd_if.sv
ptg_table.sv
ptg_search.sv
page_walker.sv
ptw_top.sv
ptw_properties.sv
tb_ptw.sv

// File: page_walker.sv
/* Hashed page-table walker: accepts a miss, reads groups in probe order,
   searches each and holds one response until it is taken */

`timescale 1ns/1ps

`include "ptw_config.svh"

module page_walker (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             req_valid,
	output logic             req_ready,
	input  ptw_pkg::vaddr_t  req_vaddr,
	input  ptw_pkg::asid_t   req_asid,
	output logic             rsp_valid,
	input  logic             rsp_ready,
	output logic             rsp_found,
	output ptw_pkg::pte_t    rsp_pte,
	output ptw_pkg::slot_t   rsp_slot,
	output ptw_pkg::group_t  rsp_group,
	ptg_rd_if.walker         rd
);

	// Counter wide enough to index every probe of one walk
	localparam int PROBE_W = $clog2(`PTW_MAX_PROBES + 1);

	ptw_pkg::walk_state_t state;

	// Latched request and current probe position
	ptw_pkg::vaddr_t vaddr_q;
	ptw_pkg::asid_t  asid_q;
	ptw_pkg::group_t cur_group;
	ptw_pkg::group_t next_group;
	logic [PROBE_W-1:0] probe_cnt;

	// Search result for the group currently on the read bus
	ptw_pkg::pte_t  srch_pte;
	logic           srch_found;
	ptw_pkg::slot_t srch_slot;

	logic accept;
	logic last_probe;
	logic done;

	ptg_search ptg_search_i (
		.ptg   (rd.rd_ptg),
		.asid  (asid_q),
		.vaddr (vaddr_q),
		.pte   (srch_pte),
		.found (srch_found),
		.slot  (srch_slot)
	);

	// ======================================================================
	// Handshake and probe control
	// ======================================================================

	assign req_ready  = (state == ptw_pkg::IDLE);
	assign rsp_valid  = (state == ptw_pkg::RESP);
	assign accept     = req_valid && req_ready;

	// One read strobe per visit to READ, aimed at the current group
	assign rd.rd_en    = (state == ptw_pkg::READ);
	assign rd.rd_group = cur_group;

	assign last_probe = (probe_cnt == PROBE_W'(`PTW_MAX_PROBES - 1));
	// Walk ends on a hit or once the final group has been searched
	assign done       = (state == ptw_pkg::CHECK) && rd.rd_valid &&
	                    (srch_found || last_probe);

	// Probing steps to the following group and wraps at the table end
	assign next_group = (cur_group == ptw_pkg::group_t'(`PTW_NUM_PTG - 1)) ?
	                    '0 : cur_group + ptw_pkg::group_t'(1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ptw_pkg::IDLE;
			probe_cnt <= '0;
		end else begin
			case (state)
				ptw_pkg::IDLE: begin
					if (accept) begin
						state     <= ptw_pkg::READ;
						probe_cnt <= '0;
					end
				end
				ptw_pkg::READ: state <= ptw_pkg::CHECK;
				ptw_pkg::CHECK: begin
					// Wait here until the table has returned the group
					if (done) begin
						state <= ptw_pkg::RESP;
					end else if (rd.rd_valid) begin
						state     <= ptw_pkg::READ;
						probe_cnt <= probe_cnt + PROBE_W'(1);
					end
				end
				ptw_pkg::RESP: begin
					if (rsp_ready) begin
						state <= ptw_pkg::IDLE;
					end
				end
				default: state <= ptw_pkg::IDLE;
			endcase
		end
	end

	// ======================================================================
	// Request and response payload
	// ======================================================================

	// The first group comes straight from the hash of the miss address
	always_ff @(posedge clk) begin
		if (accept) begin
			vaddr_q   <= req_vaddr;
			asid_q    <= req_asid;
			cur_group <= ptw_pkg::ptg_hash(req_vaddr);
		end else if ((state == ptw_pkg::CHECK) && rd.rd_valid && !done) begin
			cur_group <= next_group;
		end
	end

	// Captured once per walk and left alone through back-pressure
	always_ff @(posedge clk) begin
		if (done) begin
			rsp_found <= srch_found;
			rsp_pte   <= srch_pte;
			rsp_slot  <= srch_slot;
			rsp_group <= cur_group;
		end
	end

endmodule

// File: ptg_rd_if.sv
/* Group-table read channel between the page walker and the group table */

`timescale 1ns/1ps

interface ptg_rd_if;

	// ======================================================================
	// Request side, driven by the walker
	// ======================================================================

	// Read strobe, high for a single cycle per group read
	logic rd_en;
	// Index of the group to fetch
	ptw_pkg::group_t rd_group;

	// ======================================================================
	// Return side, driven by the table one cycle after rd_en
	// ======================================================================

	// All PTEs of the addressed group
	ptw_pkg::ptg_t rd_ptg;
	// Marks the cycle in which rd_ptg holds the requested group
	logic rd_valid;

	// Walker issues reads and consumes the returned group
	modport walker (
		output rd_en,
		output rd_group,
		input  rd_ptg,
		input  rd_valid
	);

	// Table serves reads
	modport tbl (
		input  rd_en,
		input  rd_group,
		output rd_ptg,
		output rd_valid
	);

endinterface

// File: ptg_search.sv
/* Group search: combinational pick of the first PTE in a group that
   translates the given address under the given ASID */

`timescale 1ns/1ps

`include "ptw_config.svh"

module ptg_search (
	input  ptw_pkg::ptg_t   ptg,
	input  ptw_pkg::asid_t  asid,
	input  ptw_pkg::vaddr_t vaddr,
	output ptw_pkg::pte_t   pte,
	output logic            found,
	output ptw_pkg::slot_t  slot
);

	// One match flag per slot
	logic [`PTW_PTE_PER_PTG-1:0] hit;

	// ======================================================================
	// Per-slot match
	// ======================================================================

	// A slot matches when it is valid, its ASID check passes, the VPN
	// high byte equals address bits 31..24, and the VPN low byte equals
	// bits 23..16 unless the page is large
	always_comb begin : slot_match
		ptw_pkg::pte_t e;
		ptw_pkg::vpn_t vpn;
		logic          asid_ok;
		logic          vpn_ok;
		for (int k = 0; k < `PTW_PTE_PER_PTG; k++) begin
			e   = ptg[k];
			vpn = ptw_pkg::pte_vpn(e);
			// Global pages ignore the address space
			asid_ok = ptw_pkg::pte_global(e) || (ptw_pkg::pte_asid(e) == asid);
			vpn_ok  = (vpn[15:8] == vaddr[31:24]) &&
			          (ptw_pkg::pte_is_large(e) || (vpn[7:0] == vaddr[23:16]));
			hit[k]  = ptw_pkg::pte_valid(e) && asid_ok && vpn_ok;
		end
	end

	// ======================================================================
	// Priority pick
	// ======================================================================

	// Lowest slot wins; a group with no match reports a zero PTE in slot 0
	always_comb begin
		found = 1'b0;
		pte   = '0;
		slot  = '0;
		for (int k = 0; k < `PTW_PTE_PER_PTG; k++) begin
			if (hit[k] && !found) begin
				found = 1'b1;
				pte   = ptg[k];
				slot  = ptw_pkg::slot_t'(k);
			end
		end
	end

endmodule

// File: ptg_table.sv
/* Page-table group store: synchronous group read, one PTE written per
   cycle, every entry cleared to invalid by reset */

`timescale 1ns/1ps

`include "ptw_config.svh"

module ptg_table (
	input  logic             clk,
	input  logic             arst_n,
	ptg_rd_if.tbl            rd,
	input  logic             wr_en,
	input  ptw_pkg::group_t  wr_group,
	input  ptw_pkg::slot_t   wr_slot,
	input  ptw_pkg::pte_t    wr_pte
);

	// ======================================================================
	// Storage
	// ======================================================================

	// Held in flops so the whole table can be cleared in one reset
	ptw_pkg::ptg_t mem [`PTW_NUM_PTG];

	// Software load port, one slot per cycle with no back-pressure.
	// Reset zeroes every PTE so the valid bit of each is clear
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int g = 0; g < `PTW_NUM_PTG; g++) begin
				mem[g] <= '0;
			end
		end else if (wr_en) begin
			mem[wr_group][wr_slot] <= wr_pte;
		end
	end

	// ======================================================================
	// Read port
	// ======================================================================

	// The valid flag follows the strobe by one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd.rd_valid <= 1'b0;
		end else begin
			rd.rd_valid <= rd.rd_en;
		end
	end

	// Group data is only captured on a request and otherwise holds,
	// so the walker sees a steady group while it sits in CHECK
	always_ff @(posedge clk) begin
		if (rd.rd_en) begin
			rd.rd_ptg <= mem[rd.rd_group];
		end
	end

	// A write in the same cycle as a read of that group is not seen
	// by the read; the walker only reads while software is quiet

endmodule

// File: ptw_config.svh
/* Page-table walker sizing: group width, table depth and probe limit
   shared by the package, the group table and the walker */

`ifndef PTW_CONFIG_SVH
`define PTW_CONFIG_SVH

// ======================================================================
// Group table geometry
// ======================================================================

// Number of PTEs held in one page-table group
`define PTW_PTE_PER_PTG 8

// Number of groups in the on-chip table, a power of two
`define PTW_NUM_PTG 16

// ======================================================================
// Walk policy
// ======================================================================

// Groups read for a single miss before the walk reports not found
`define PTW_MAX_PROBES 2

`endif

// File: ptw_pkg.sv
/* Page-table walker types, PTE field accessors and the group hash */

`include "ptw_config.svh"

package ptw_pkg;

	// Virtual address of a translation miss
	typedef logic [31:0] vaddr_t;

	// Address-space id carried by requests and non-global PTEs
	typedef logic [9:0] asid_t;

	// Virtual page number field of a PTE, high byte then low byte
	typedef logic [15:0] vpn_t;

	// A PTE as one vector, v g mb me asid vpn rsvd ppn from the top down
	typedef logic [63:0] pte_t;

	// One group is the PTEs side by side, slot 0 in the low bits
	typedef pte_t [`PTW_PTE_PER_PTG-1:0] ptg_t;

	typedef logic [$clog2(`PTW_PTE_PER_PTG)-1:0] slot_t;
	typedef logic [$clog2(`PTW_NUM_PTG)-1:0] group_t;

	// Walker FSM states
	typedef enum logic [1:0] {IDLE, READ, CHECK, RESP} walk_state_t;

	function automatic logic pte_valid(input pte_t p);
		return p[63];
	endfunction

	function automatic logic pte_global(input pte_t p);
		return p[62];
	endfunction

	function automatic asid_t pte_asid(input pte_t p);
		return p[55:46];
	endfunction

	function automatic vpn_t pte_vpn(input pte_t p);
		return p[45:30];
	endfunction

	// A large page is marked by mb = 7 and me = 2
	function automatic logic pte_is_large(input pte_t p);
		return (p[61:59] == 3'd7) && (p[58:56] == 3'd2);
	endfunction

	// First group probed for an address. The ASID stays out of the hash
	// so a global page lands in the same group for every address space
	function automatic group_t ptg_hash(input vaddr_t va);
		return group_t'(va[31:28] ^ va[27:24]);
	endfunction

endpackage

// File: ptw_properties.sv
/* Protocol checks bound to the walker top: reset values, one walk in
   flight, stable response under back-pressure */

`timescale 1ns/1ps

module ptw_properties (
	input logic                  clk,
	input logic                  arst_n,
	input logic                  req_valid,
	input logic                  req_ready,
	input logic                  rsp_valid,
	input logic                  rsp_ready,
	input logic                  rsp_found,
	input ptw_pkg::pte_t         rsp_pte,
	input ptw_pkg::slot_t        rsp_slot,
	input ptw_pkg::group_t       rsp_group
);

	// Set by an accepted request and cleared by the response handshake
	logic busy;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
		end else if (req_valid && req_ready) begin
			busy <= 1'b1;
		end else if (rsp_valid && rsp_ready) begin
			busy <= 1'b0;
		end
	end

	// ======================================================================
	// Reset behaviour
	// ======================================================================

	a_rsp_low_in_reset: assert property (@(posedge clk) !arst_n |-> !rsp_valid)
		else $error("rsp_valid high while reset is asserted");

	// First cycle out of reset finds the walker idle
	a_idle_after_reset: assert property (@(posedge clk)
		$rose(arst_n) |-> (req_ready && !rsp_valid))
		else $error("walker not idle right after reset");

	// ======================================================================
	// Handshake rules
	// ======================================================================

	a_no_accept_busy: assert property (@(posedge clk) disable iff (!arst_n)
		busy |-> !req_ready)
		else $error("req_ready high while a walk is pending");

	// Everything the response carries holds until it is taken
	a_rsp_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_found) &&
		$stable(rsp_pte) && $stable(rsp_slot) && $stable(rsp_group)))
		else $error("response changed under back-pressure");

	a_rsp_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(rsp_valid) |-> busy)
		else $error("rsp_valid rose with no accepted request");

endmodule

bind ptw_top ptw_properties ptw_properties_i (
	.clk       (clk),
	.arst_n    (arst_n),
	.req_valid (req_valid),
	.req_ready (req_ready),
	.rsp_valid (rsp_valid),
	.rsp_ready (rsp_ready),
	.rsp_found (rsp_found),
	.rsp_pte   (rsp_pte),
	.rsp_slot  (rsp_slot),
	.rsp_group (rsp_group)
);

// File: ptw_top.sv
/* Page-table walker top: walker and group table joined by the group
   read channel, with plain request, response and table-load ports */

`timescale 1ns/1ps

module ptw_top (
	input  logic             clk,
	input  logic             arst_n,

	// Translation-miss request
	input  logic             req_valid,
	output logic             req_ready,
	input  ptw_pkg::vaddr_t  req_vaddr,
	input  ptw_pkg::asid_t   req_asid,

	// Walk result
	output logic             rsp_valid,
	input  logic             rsp_ready,
	output logic             rsp_found,
	output ptw_pkg::pte_t    rsp_pte,
	output ptw_pkg::slot_t   rsp_slot,
	output ptw_pkg::group_t  rsp_group,

	// Software table load, always accepted
	input  logic             wr_en,
	input  ptw_pkg::group_t  wr_group,
	input  ptw_pkg::slot_t   wr_slot,
	input  ptw_pkg::pte_t    wr_pte
);

	// ======================================================================
	// Group read channel
	// ======================================================================

	ptg_rd_if rd_bus ();

	// Table answers group reads one cycle after the strobe
	ptg_table ptg_table_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.rd       (rd_bus.tbl),
		.wr_en    (wr_en),
		.wr_group (wr_group),
		.wr_slot  (wr_slot),
		.wr_pte   (wr_pte)
	);

	// Walker runs one miss at a time against the table
	page_walker page_walker_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_vaddr (req_vaddr),
		.req_asid  (req_asid),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_found (rsp_found),
		.rsp_pte   (rsp_pte),
		.rsp_slot  (rsp_slot),
		.rsp_group (rsp_group),
		.rd        (rd_bus.walker)
	);

endmodule

// File: tb_ptw.sv
/* Testbench for the page-table walker with directed and LFSR-driven walks
   checked against a shadow table model at every response handshake */

`timescale 1ns/1ps

`include "ptw_config.svh"

module tb_ptw;

	// Worst walk in cycles, from issue to the handshake edge without stalls
	localparam int WORST_WALK = 3 + 2 * (`PTW_MAX_PROBES - 1) + 2;
	localparam int N_RANDOM   = 60;
	localparam int N_REQ      = N_RANDOM + 16;
	localparam int N_WR       = 12;
	// Stall allowance of 8 cycles per walk on top of the latency
	localparam int LIMIT_CYC  = 2 * (WORST_WALK + 8) * N_REQ + 2 * N_WR + 20;

	logic clk;
	logic arst_n;
	logic req_valid;
	logic req_ready;
	logic rsp_valid;
	logic rsp_ready;
	logic rsp_found;
	logic wr_en;
	ptw_pkg::vaddr_t vaddr;
	ptw_pkg::asid_t  asid;
	ptw_pkg::pte_t   rsp_pte;
	ptw_pkg::pte_t   wr_pte;
	ptw_pkg::slot_t  rsp_slot;
	ptw_pkg::slot_t  wr_slot;
	ptw_pkg::group_t rsp_group;
	ptw_pkg::group_t wr_group;

	// Shadow of every table write and the prediction for the walk in flight
	ptw_pkg::pte_t   shadow [`PTW_NUM_PTG][`PTW_PTE_PER_PTG];
	logic            exp_found;
	ptw_pkg::pte_t   exp_pte;
	ptw_pkg::slot_t  exp_slot;
	ptw_pkg::group_t exp_group;
	logic [15:0]     lfsr;

	ptw_top ptw_top_i (
		.clk(clk), .arst_n(arst_n),
		.req_valid(req_valid), .req_ready(req_ready),
		.req_vaddr(vaddr), .req_asid(asid),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_found(rsp_found),
		.rsp_pte(rsp_pte), .rsp_slot(rsp_slot), .rsp_group(rsp_group),
		.wr_en(wr_en), .wr_group(wr_group), .wr_slot(wr_slot), .wr_pte(wr_pte)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Feedback from taps 16 14 13 11 shifts in one new bit per call
	function automatic logic rand_bit();
		logic fb;
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[6:0], rand_bit()};
		end
		return r;
	endfunction

	function automatic ptw_pkg::pte_t make_pte(input logic g, input logic [2:0] mb,
			input logic [2:0] me, input ptw_pkg::asid_t a, input logic [15:0] vpn,
			input logic [21:0] ppn);
		return {1'b1, g, mb, me, a, vpn, 8'h00, ppn};
	endfunction

	// ======================================================================
	// Reference model of the hash, probe order and match rule
	// ======================================================================

	task automatic predict(input ptw_pkg::vaddr_t va, input ptw_pkg::asid_t a);
		logic [3:0]  g;
		logic [63:0] e;
		logic        m;
		g = va[31:28] ^ va[27:24];
		exp_found = 1'b0;
		exp_pte   = '0;
		exp_slot  = '0;
		for (int p = 0; p < `PTW_MAX_PROBES && !exp_found; p++) begin
			exp_group = g;
			for (int s = 0; s < `PTW_PTE_PER_PTG; s++) begin
				e = shadow[g][s];
				m = e[63] && (e[62] || e[55:46] == a) && (e[45:38] == va[31:24]) &&
				    ((e[61:56] == 6'b111_010) || (e[37:30] == va[23:16]));
				if (m && !exp_found) begin
					exp_found = 1'b1;
					exp_pte   = e;
					exp_slot  = s[2:0];
				end
			end
			g = g + 4'd1;
		end
	endtask

	task automatic report_mismatch();
		if (rsp_found !== exp_found)
			$display("CHECK FAILED t=%0t rsp_found exp=%0b act=%0b",
			         $time, exp_found, rsp_found);
		else if (rsp_pte !== exp_pte)
			$display("CHECK FAILED t=%0t rsp_pte exp=%h act=%h",
			         $time, exp_pte, rsp_pte);
		else if (rsp_slot !== exp_slot)
			$display("CHECK FAILED t=%0t rsp_slot exp=%0d act=%0d",
			         $time, exp_slot, rsp_slot);
		else
			$display("CHECK FAILED t=%0t rsp_group exp=%0d act=%0d",
			         $time, exp_group, rsp_group);
		$display("*** FAILED ***");
		$fatal(1, "response mismatch");
	endtask

	// Prediction is taken at acceptance and compared at the handshake
	always @(posedge clk) begin
		if (arst_n && req_valid && req_ready) begin
			predict(vaddr, asid);
		end
		if (arst_n && rsp_valid && rsp_ready) begin
			assert (rsp_found === exp_found && rsp_pte === exp_pte &&
			        rsp_slot === exp_slot && rsp_group === exp_group)
				else report_mismatch();
		end
	end

	task automatic write_pte(input int g, input int s, input ptw_pkg::pte_t p);
		@(posedge clk);
		wr_en    <= 1'b1;
		wr_group <= g[3:0];
		wr_slot  <= s[2:0];
		wr_pte   <= p;
		shadow[g][s] = p;
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	// One walk with random stalls on rsp_ready until the handshake
	task automatic walk(input ptw_pkg::vaddr_t va, input ptw_pkg::asid_t a);
		logic taken;
		@(posedge clk);
		req_valid <= 1'b1;
		vaddr     <= va;
		asid      <= a;
		rsp_ready <= rand_bit();
		@(posedge clk);
		req_valid <= 1'b0;
		taken = 1'b0;
		while (!taken) begin
			rsp_ready <= rand_bit();
			@(posedge clk);
			taken = rsp_valid && rsp_ready;
		end
		rsp_ready <= 1'b0;
	endtask

	initial begin
		#(LIMIT_CYC * 4);
		$display("Watchdog expired before all walks completed");
		$display("*** FAILED ***");
		$fatal(1, "timeout");
	end

	initial begin
		logic [7:0] hi_tbl [8];
		logic [7:0] lo_tbl [8];
		logic [7:0] hi;
		logic [7:0] lo;
		hi_tbl = '{8'h12, 8'h57, 8'h9B, 8'hC4, 8'hD5, 8'h21, 8'h33, 8'hF0};
		lo_tbl = '{8'h00, 8'h34, 8'hAB, 8'h10, 8'h01, 8'h55, 8'h66, 8'h20};
		lfsr      = 16'd8038;
		arst_n    = 1'b0;
		req_valid = 1'b0;
		rsp_ready = 1'b0;
		vaddr     = '0;
		asid      = '0;
		wr_en     = 1'b0;
		wr_group  = '0;
		wr_slot   = '0;
		wr_pte    = '0;
		for (int g = 0; g < `PTW_NUM_PTG; g++)
			for (int s = 0; s < `PTW_PTE_PER_PTG; s++)
				shadow[g][s] = '0;
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;

		// Empty table answers not found
		walk(32'h1234_5000, 10'd5);

		// ======================================================================
		// Table load
		// ======================================================================
		write_pte(3, 2, make_pte(0, 3'd0, 3'd0, 10'd5, 16'h1234, 22'h00A1));
		write_pte(2, 0, make_pte(1, 3'd0, 3'd0, 10'd9, 16'h5700, 22'h00B2));
		write_pte(2, 1, make_pte(0, 3'd0, 3'd0, 10'd7, 16'h9B00, 22'h00C3));
		write_pte(8, 0, make_pte(0, 3'd7, 3'd2, 10'd3, 16'hC400, 22'h00D4));
		write_pte(8, 1, make_pte(0, 3'd7, 3'd3, 10'd3, 16'hD500, 22'h00E5));
		write_pte(3, 4, make_pte(0, 3'd0, 3'd0, 10'd1, 16'h21AB, 22'h0101));
		write_pte(3, 6, make_pte(0, 3'd0, 3'd0, 10'd1, 16'h21AB, 22'h0202));
		write_pte(1, 0, make_pte(0, 3'd0, 3'd0, 10'd1, 16'h3310, 22'h0303));
		write_pte(2, 7, make_pte(0, 3'd0, 3'd0, 10'd1, 16'h4420, 22'h0404));
		write_pte(0, 3, make_pte(0, 3'd0, 3'd0, 10'd1, 16'hF001, 22'h0505));

		// Small page, ASID rules, large page, priority and probing
		walk(32'h1234_5000, 10'd5);
		walk(32'h5700_0000, 10'd100);
		walk(32'h9B00_0000, 10'd8);
		walk(32'h9B00_0000, 10'd7);
		walk(32'hC455_1000, 10'd3);
		walk(32'hD566_0000, 10'd3);
		walk(32'hD500_0000, 10'd3);
		walk(32'h21AB_0000, 10'd1);
		walk(32'h3310_0000, 10'd1);
		walk(32'h4420_0000, 10'd1);
		walk(32'hF001_0000, 10'd1);

		// Random walks over the loaded pages under random stalls
		for (int i = 0; i < N_RANDOM; i++) begin
			hi = hi_tbl[3'(rand_bits(3))];
			lo = lo_tbl[3'(rand_bits(3))];
			walk({hi, lo, rand_bits(8), 8'h00}, {rand_bits(2), 2'b01});
		end

		repeat (4) @(posedge clk);
		$display("*** PASSED ***");
		$finish;
	end

endmodule
